//--- Bender.yml
package:
  name: fp_add

sources:
  - fp_add_pkg.sv
  - align_shifter.sv
  - fp_unpack.sv
  - fp_align.sv
  - fp_add_norm.sv
  - fp_round_pack.sv
  - fp_add_top.sv
  - target: test
    files:
      - fp_add_asserts.sv
      - tb_fp_add.sv

//--- align_shifter.sv
`timescale 1ns/1ps
`default_nettype none

module align_shifter (
    input  wire logic                                          clk,
    input  wire logic                                          rstn,
    input  wire logic                                          valid_in,
    input  wire logic [fp_add_pkg::exp_w-1:0]                  shift,
    input  wire logic [fp_add_pkg::sig_w-1:0]                  in_data,
    output logic                                               valid_out,
    output logic [fp_add_pkg::sig_w+fp_add_pkg::grs_w-1:0]     out_data
);
    import fp_add_pkg::*;

    localparam int ext_w = sig_w + grs_w;

    // significand parked above a field wide enough for every kept shift
    logic [sig_w+ext_w-1:0] wide;
    logic [ext_w-1:0]       shifted;

    assign wide = {in_data, {ext_w{1'b0}}} >> shift;

    always_comb begin
        if (shift >= ext_w) begin
            // everything lands in sticky
            shifted = {{(ext_w-1){1'b0}}, |in_data};
        end else begin
            // top bits are significand, guard, round; the rest folds into sticky
            shifted = {wide[sig_w+ext_w-1:ext_w-2], |wide[ext_w-3:0]};
        end
    end

    always_ff @(posedge clk or negedge rstn) begin
        if (!rstn) begin
            valid_out <= 1'b0;
            out_data  <= '0;
        end else begin
            valid_out <= valid_in;
            if (valid_in) begin
                out_data <= shifted;
            end
        end
    end

endmodule

`default_nettype wire

//--- fp_add_asserts.sv
`timescale 1ns/1ps
`default_nettype none

module fp_add_asserts (
    input  wire logic                                          clk,
    input  wire logic                                          rstn,
    input  wire logic                                          valid_in,
    input  wire logic                                          valid_out,
    input  wire logic [fp_add_pkg::exp_w+fp_add_pkg::man_w:0]  result
);
    import fp_add_pkg::*;

    // number of failed assertions so far
    int fail_count = 0;

    //////////////////////////////
    // strobe timing
    //////////////////////////////

    // each input strobe reappears after the pipeline latency
    strobe_latency_a: assert property (@(posedge clk) disable iff (!rstn)
        valid_in |-> ##fp_add_latency valid_out)
    else begin
        fail_count++;
        $error("valid_out missing %0d cycles after valid_in", fp_add_latency);
    end

    // no output strobe without a matching input strobe
    no_extra_strobe_a: assert property (@(posedge clk) disable iff (!rstn)
        valid_out |-> $past(valid_in, fp_add_latency))
    else begin
        fail_count++;
        $error("valid_out without valid_in %0d cycles earlier", fp_add_latency);
    end

    // quiet output while in reset
    reset_quiet_a: assert property (@(posedge clk)
        !rstn |-> !valid_out)
    else begin
        fail_count++;
        $error("valid_out high during reset");
    end

    //////////////////////////////
    // output data
    //////////////////////////////

    known_result_a: assert property (@(posedge clk) disable iff (!rstn)
        valid_out |-> !$isunknown(result))
    else begin
        fail_count++;
        $error("result has unknown bits while valid_out is high");
    end

endmodule

`default_nettype wire

//--- fp_add_norm.sv
`timescale 1ns/1ps
`default_nettype none

module fp_add_norm (
    input  wire logic                                          clk,
    input  wire logic                                          rstn,
    // from align
    input  wire logic                                          s2_valid,
    input  wire logic [fp_add_pkg::sig_w-1:0]                  s2_big_sig,
    input  wire logic [fp_add_pkg::sig_w+fp_add_pkg::grs_w-1:0] s2_small_ext,
    input  wire logic [fp_add_pkg::exp_w-1:0]                  s2_exp,
    input  wire logic                                          s2_sign,
    input  wire logic                                          s2_sub,
    input  wire logic                                          s2_special,
    input  wire logic [fp_add_pkg::exp_w+fp_add_pkg::man_w:0]  s2_special_val,
    // to round/pack
    output logic                                               s3_valid,
    output logic [fp_add_pkg::sig_w+fp_add_pkg::grs_w-1:0]     s3_sig,
    output logic signed [fp_add_pkg::exp_w+1:0]                s3_exp,
    output logic                                               s3_sign,
    output logic                                               s3_zero,
    output logic                                               s3_special,
    output logic [fp_add_pkg::exp_w+fp_add_pkg::man_w:0]       s3_special_val
);
    import fp_add_pkg::*;

    localparam int ext_w = sig_w + grs_w;

    // leading zero count, ext_w when all zero
    function automatic logic [4:0] lzc(input logic [ext_w-1:0] v);
        logic [4:0] n;
        logic       found;
        int         i;
        n     = 5'(ext_w);
        found = 1'b0;
        for (i = ext_w - 1; i >= 0; i--) begin
            if (!found && v[i]) begin
                n     = 5'(ext_w - 1 - i);
                found = 1'b1;
            end
        end
        return n;
    endfunction

    logic [ext_w-1:0]          big_ext;
    // one extra bit for the carry
    logic [ext_w:0]            sum;
    logic [4:0]                lz;
    logic [ext_w-1:0]          norm_sig;
    logic signed [exp_w+1:0]   norm_exp;
    logic                      zero;

    assign big_ext = {s2_big_sig, {grs_w{1'b0}}};
    // big >= small in magnitude, so the difference never goes negative
    assign sum  = s2_sub ? ({1'b0, big_ext} - {1'b0, s2_small_ext})
                         : ({1'b0, big_ext} + {1'b0, s2_small_ext});
    assign lz   = lzc(sum[ext_w-1:0]);
    assign zero = (sum == '0);

    always_comb begin
        if (sum[ext_w]) begin
            // carry out, shift down one, last bit stays sticky
            norm_sig = {sum[ext_w:2], sum[1] | sum[0]};
            norm_exp = $signed({2'b00, s2_exp}) + 10'sd1;
        end else begin
            // cancellation, pull leading one up to the top
            norm_sig = sum[ext_w-1:0] << lz;
            norm_exp = $signed({2'b00, s2_exp}) - $signed({5'b00000, lz});
        end
    end

    always_ff @(posedge clk or negedge rstn) begin
        if (!rstn) begin
            s3_valid       <= 1'b0;
            s3_sig         <= '0;
            s3_exp         <= '0;
            s3_sign        <= 1'b0;
            s3_zero        <= 1'b0;
            s3_special     <= 1'b0;
            s3_special_val <= '0;
        end else begin
            s3_valid <= s2_valid;
            if (s2_valid) begin
                s3_sig         <= norm_sig;
                s3_exp         <= norm_exp;
                // exact cancellation is +0, zero plus zero keeps its sign
                s3_sign        <= (zero && s2_sub) ? 1'b0 : s2_sign;
                s3_zero        <= zero;
                s3_special     <= s2_special;
                s3_special_val <= s2_special_val;
            end
        end
    end

endmodule

`default_nettype wire

//--- fp_add_pkg.sv
`default_nettype none

package fp_add_pkg;

    //////////////////////////////
    // binary32 format
    //////////////////////////////

    // biased exponent field
    localparam int exp_w = 8;
    // stored fraction, hidden bit not included
    localparam int man_w = 23;
    // significand with hidden bit
    localparam int sig_w = 24;
    // guard, round, sticky
    localparam int grs_w = 3;

    localparam int exp_bias = 127;
    // all-ones exponent, inf and nan
    localparam int exp_max = 255;

    // canonical quiet nan
    localparam logic [31:0] qnan = 32'h7fc0_0000;

    //////////////////////////////
    // pipeline
    //////////////////////////////

    // unpack, align, add/normalize, round/pack
    localparam int fp_add_latency = 4;

endpackage

`default_nettype wire

//--- fp_add_tests.txt
# test name, operand a, operand b and expected sum on each line
# all three values are binary32 bit patterns in hex
add_one_one         3f800000 3f800000 40000000
add_one_two         3f800000 40000000 40400000
add_frac            3fc00000 3e800000 3fe00000
add_neg_neg         bf800000 c0000000 c0400000
add_tenth_tenth     3dcccccd 3dcccccd 3e4ccccd
add_tenth_fifth     3dcccccd 3e4ccccd 3e99999a
add_shift25_round   3f800000 33000000 3f800000
add_shift30_sticky  3f800000 30800000 3f800000
add_shift126        3f800000 00800000 3f800000
sub_ten_five        41200000 c0a00000 40a00000
sub_three_one       40400000 bf800000 40000000
sub_frac            3fc00000 bfa00000 3e800000
sub_cancel_pos      3f800001 bf800000 34000000
sub_cancel_neg      bf800001 3f800000 b4000000
sub_shift24         3f800000 b3800000 3f7fffff
sub_round_carry     3f800000 b3000000 3f800000
sub_sticky_only     3f800000 b0800000 3f800000
sub_exact_zero      3f800000 bf800000 00000000
sub_exact_zero_rev  bf800000 3f800000 00000000
rnd_tie_even_down   3f800000 33800000 3f800000
rnd_tie_even_up     3f800001 33800000 3f800002
rnd_above_half      3f800000 33800001 3f800001
rnd_carry_exp       3fffffff 33800000 40000000
rnd_carry_big       4b7fffff 3f000000 4b800000
ovf_pos             7f7fffff 7f7fffff 7f800000
ovf_neg             ff7fffff ff7fffff ff800000
ovf_round           7f7fffff 73000000 7f800000
unf_pos             00800001 80800000 00000000
unf_neg             80800001 00800000 80000000
dnorm_pos           00000001 00000001 00000000
dnorm_neg           80000001 80000001 80000000
dnorm_normal        00400000 3f800000 3f800000
zero_neg_neg        80000000 80000000 80000000
nan_a               7fc00000 3f800000 7fc00000
nan_b               3f800000 7f800001 7fc00000
inf_plus_fin        7f800000 3f800000 7f800000
fin_plus_ninf       3f800000 ff800000 ff800000
inf_minus_inf       7f800000 ff800000 7fc00000

//--- fp_add_top.sv
`timescale 1ns/1ps
`default_nettype none

module fp_add_top (
    input  wire logic                                          clk,
    input  wire logic                                          rstn,
    input  wire logic                                          valid_in,
    input  wire logic [fp_add_pkg::exp_w+fp_add_pkg::man_w:0]  a,
    input  wire logic [fp_add_pkg::exp_w+fp_add_pkg::man_w:0]  b,
    output logic                                               valid_out,
    output logic [fp_add_pkg::exp_w+fp_add_pkg::man_w:0]       result
);
    import fp_add_pkg::*;

    // stage 1 to 2
    logic                      s1_valid, s1_sign, s1_sub, s1_special;
    logic [sig_w-1:0]          s1_big_sig, s1_small_sig;
    logic [exp_w-1:0]          s1_shift, s1_exp;
    logic [exp_w+man_w:0]      s1_special_val;
    // stage 2 to 3
    logic                      s2_valid, s2_sign, s2_sub, s2_special;
    logic [sig_w-1:0]          s2_big_sig;
    logic [sig_w+grs_w-1:0]    s2_small_ext;
    logic [exp_w-1:0]          s2_exp;
    logic [exp_w+man_w:0]      s2_special_val;
    // stage 3 to 4
    logic                      s3_valid, s3_sign, s3_zero, s3_special;
    logic [sig_w+grs_w-1:0]    s3_sig;
    logic signed [exp_w+1:0]   s3_exp;
    logic [exp_w+man_w:0]      s3_special_val;

    fp_unpack unpack_i (
        .clk, .rstn, .valid_in, .a, .b,
        .s1_valid, .s1_big_sig, .s1_small_sig, .s1_shift, .s1_exp,
        .s1_sign, .s1_sub, .s1_special, .s1_special_val
    );

    fp_align align_i (
        .clk, .rstn,
        .s1_valid, .s1_big_sig, .s1_small_sig, .s1_shift, .s1_exp,
        .s1_sign, .s1_sub, .s1_special, .s1_special_val,
        .s2_valid, .s2_big_sig, .s2_small_ext, .s2_exp,
        .s2_sign, .s2_sub, .s2_special, .s2_special_val
    );

    fp_add_norm norm_i (
        .clk, .rstn,
        .s2_valid, .s2_big_sig, .s2_small_ext, .s2_exp,
        .s2_sign, .s2_sub, .s2_special, .s2_special_val,
        .s3_valid, .s3_sig, .s3_exp, .s3_sign, .s3_zero,
        .s3_special, .s3_special_val
    );

    fp_round_pack round_i (
        .clk, .rstn,
        .s3_valid, .s3_sig, .s3_exp, .s3_sign, .s3_zero,
        .s3_special, .s3_special_val,
        .valid_out, .result
    );

endmodule

`default_nettype wire

//--- fp_align.sv
`timescale 1ns/1ps
`default_nettype none

module fp_align (
    input  wire logic                                          clk,
    input  wire logic                                          rstn,
    // from unpack
    input  wire logic                                          s1_valid,
    input  wire logic [fp_add_pkg::sig_w-1:0]                  s1_big_sig,
    input  wire logic [fp_add_pkg::sig_w-1:0]                  s1_small_sig,
    input  wire logic [fp_add_pkg::exp_w-1:0]                  s1_shift,
    input  wire logic [fp_add_pkg::exp_w-1:0]                  s1_exp,
    input  wire logic                                          s1_sign,
    input  wire logic                                          s1_sub,
    input  wire logic                                          s1_special,
    input  wire logic [fp_add_pkg::exp_w+fp_add_pkg::man_w:0]  s1_special_val,
    // to add/normalize
    output logic                                               s2_valid,
    output logic [fp_add_pkg::sig_w-1:0]                       s2_big_sig,
    output logic [fp_add_pkg::sig_w+fp_add_pkg::grs_w-1:0]     s2_small_ext,
    output logic [fp_add_pkg::exp_w-1:0]                       s2_exp,
    output logic                                               s2_sign,
    output logic                                               s2_sub,
    output logic                                               s2_special,
    output logic [fp_add_pkg::exp_w+fp_add_pkg::man_w:0]       s2_special_val
);
    import fp_add_pkg::*;

    // smaller operand shifted down to the larger exponent
    align_shifter shifter_i (
        .clk       (clk),
        .rstn      (rstn),
        .valid_in  (s1_valid),
        .shift     (s1_shift),
        .in_data   (s1_small_sig),
        .valid_out (s2_valid),
        .out_data  (s2_small_ext)
    );

    // side fields, same strobe, same cycle as the shifter
    always_ff @(posedge clk or negedge rstn) begin
        if (!rstn) begin
            s2_big_sig     <= '0;
            s2_exp         <= '0;
            s2_sign        <= 1'b0;
            s2_sub         <= 1'b0;
            s2_special     <= 1'b0;
            s2_special_val <= '0;
        end else if (s1_valid) begin
            s2_big_sig     <= s1_big_sig;
            s2_exp         <= s1_exp;
            s2_sign        <= s1_sign;
            s2_sub         <= s1_sub;
            s2_special     <= s1_special;
            s2_special_val <= s1_special_val[exp_w+man_w:0];
        end
    end

endmodule

`default_nettype wire

//--- fp_round_pack.sv
`timescale 1ns/1ps
`default_nettype none

module fp_round_pack (
    input  wire logic                                          clk,
    input  wire logic                                          rstn,
    // from add/normalize
    input  wire logic                                          s3_valid,
    input  wire logic [fp_add_pkg::sig_w+fp_add_pkg::grs_w-1:0] s3_sig,
    input  wire logic signed [fp_add_pkg::exp_w+1:0]           s3_exp,
    input  wire logic                                          s3_sign,
    input  wire logic                                          s3_zero,
    input  wire logic                                          s3_special,
    input  wire logic [fp_add_pkg::exp_w+fp_add_pkg::man_w:0]  s3_special_val,
    // packed sum
    output logic                                               valid_out,
    output logic [fp_add_pkg::exp_w+fp_add_pkg::man_w:0]       result
);
    import fp_add_pkg::*;

    //////////////////////////////
    // round to nearest even
    //////////////////////////////

    logic                      lsb, guard, round_bit, sticky;
    logic                      round_up;
    // significand plus a carry bit
    logic [sig_w:0]            rounded;
    logic [man_w-1:0]          frac;
    logic signed [exp_w+1:0]   exp_r;
    logic [31:0]               packed_val;

    assign lsb       = s3_sig[grs_w];
    assign guard     = s3_sig[2];
    assign round_bit = s3_sig[1];
    assign sticky    = s3_sig[0];

    // above half, or exact half with odd lsb
    assign round_up = guard & (round_bit | sticky | lsb);
    assign rounded  = {1'b0, s3_sig[sig_w+grs_w-1:grs_w]} + (sig_w+1)'(round_up);

    // carry out leaves 1.000..., fraction all zero
    assign frac  = rounded[man_w-1:0];
    assign exp_r = s3_exp + $signed({9'b0, rounded[sig_w]});

    //////////////////////////////
    // result select
    //////////////////////////////

    always_comb begin
        if (s3_special) begin
            packed_val = s3_special_val;
        end else if (s3_zero) begin
            packed_val = {s3_sign, {(exp_w+man_w){1'b0}}};
        end else if (exp_r >= exp_max) begin
            // overflow
            packed_val = {s3_sign, exp_w'(exp_max), {man_w{1'b0}}};
        end else if (exp_r <= 0) begin
            // would be subnormal or less, flush
            packed_val = {s3_sign, {(exp_w+man_w){1'b0}}};
        end else begin
            packed_val = {s3_sign, exp_r[exp_w-1:0], frac};
        end
    end

    always_ff @(posedge clk or negedge rstn) begin
        if (!rstn) begin
            valid_out <= 1'b0;
            result    <= '0;
        end else begin
            valid_out <= s3_valid;
            // last sum holds between strobes
            if (s3_valid) begin
                result <= packed_val;
            end
        end
    end

endmodule

`default_nettype wire

//--- fp_unpack.sv
`timescale 1ns/1ps
`default_nettype none

module fp_unpack (
    input  wire logic                                      clk,
    input  wire logic                                      rstn,
    input  wire logic                                      valid_in,
    input  wire logic [fp_add_pkg::exp_w+fp_add_pkg::man_w:0] a,
    input  wire logic [fp_add_pkg::exp_w+fp_add_pkg::man_w:0] b,
    output logic                                           s1_valid,
    output logic [fp_add_pkg::sig_w-1:0]                   s1_big_sig,
    output logic [fp_add_pkg::sig_w-1:0]                   s1_small_sig,
    output logic [fp_add_pkg::exp_w-1:0]                   s1_shift,
    output logic [fp_add_pkg::exp_w-1:0]                   s1_exp,
    output logic                                           s1_sign,
    output logic                                           s1_sub,
    output logic                                           s1_special,
    output logic [fp_add_pkg::exp_w+fp_add_pkg::man_w:0]   s1_special_val
);
    import fp_add_pkg::*;

    // field split
    logic               a_sign, b_sign;
    logic [exp_w-1:0]   a_exp, b_exp;
    logic [man_w-1:0]   a_man, b_man;
    logic [sig_w-1:0]   a_sig, b_sig;
    // classification
    logic               a_nan, b_nan, a_inf, b_inf;
    logic               a_big;
    logic               special;
    logic [31:0]        special_val;

    assign a_sign = a[exp_w+man_w];
    assign b_sign = b[exp_w+man_w];
    assign a_exp  = a[exp_w+man_w-1:man_w];
    assign b_exp  = b[exp_w+man_w-1:man_w];
    assign a_man  = a[man_w-1:0];
    assign b_man  = b[man_w-1:0];

    // zero exponent means zero or subnormal, both flushed to zero
    assign a_sig = (a_exp == '0) ? '0 : {1'b1, a_man};
    assign b_sig = (b_exp == '0) ? '0 : {1'b1, b_man};

    assign a_nan = (a_exp == exp_max) && (a_man != '0);
    assign b_nan = (b_exp == exp_max) && (b_man != '0);
    assign a_inf = (a_exp == exp_max) && (a_man == '0);
    assign b_inf = (b_exp == exp_max) && (b_man == '0);

    // magnitude order, exponent then fraction, is plain unsigned compare
    assign a_big = (a[exp_w+man_w-1:0] >= b[exp_w+man_w-1:0]);

    // nan in, or opposite infinities
    assign special = a_nan | b_nan | a_inf | b_inf;
    always_comb begin
        if (a_nan || b_nan || (a_inf && b_inf && (a_sign != b_sign))) begin
            special_val = qnan;
        end else if (a_inf) begin
            special_val = {a_sign, exp_w'(exp_max), {man_w{1'b0}}};
        end else begin
            special_val = {b_sign, exp_w'(exp_max), {man_w{1'b0}}};
        end
    end

    always_ff @(posedge clk or negedge rstn) begin
        if (!rstn) begin
            s1_valid       <= 1'b0;
            s1_big_sig     <= '0;
            s1_small_sig   <= '0;
            s1_shift       <= '0;
            s1_exp         <= '0;
            s1_sign        <= 1'b0;
            s1_sub         <= 1'b0;
            s1_special     <= 1'b0;
            s1_special_val <= '0;
        end else begin
            s1_valid <= valid_in;
            // hold between strobes
            if (valid_in) begin
                s1_big_sig     <= a_big ? a_sig : b_sig;
                s1_small_sig   <= a_big ? b_sig : a_sig;
                s1_shift       <= a_big ? (a_exp - b_exp) : (b_exp - a_exp);
                s1_exp         <= a_big ? a_exp : b_exp;
                s1_sign        <= a_big ? a_sign : b_sign;
                s1_sub         <= a_sign ^ b_sign;
                s1_special     <= special;
                s1_special_val <= special_val;
            end
        end
    end

endmodule

`default_nettype wire

//--- tb_fp_add.sv
`timescale 1ns/1ps
`default_nettype none

module tb_fp_add;
    import fp_add_pkg::*;

    localparam int clk_period = 10;
    localparam tests_file = "fp_add_tests.txt";

    logic        clk;
    logic        rstn;
    logic        valid_in;
    logic [31:0] a;
    logic [31:0] b;
    logic        valid_out;
    logic [31:0] result;

    // vectors from the data file
    string       test_name[$];
    logic [31:0] op_a[$];
    logic [31:0] op_b[$];
    logic [31:0] expected[$];
    // cycle at which each sum should show up
    int          due_cycle[$];

    int          n_tests = 0;
    int          rx_count = 0;
    int          passed = 0;
    int          errors = 0;
    int          cycle = 0;
    logic        loaded = 1'b0;
    logic [31:0] lcg_state = 32'h144263d8;

    fp_add_top dut_i (
        .clk       (clk),
        .rstn      (rstn),
        .valid_in  (valid_in),
        .a         (a),
        .b         (b),
        .valid_out (valid_out),
        .result    (result)
    );

    bind fp_add_top fp_add_asserts asserts_i (
        .clk       (clk),
        .rstn      (rstn),
        .valid_in  (valid_in),
        .valid_out (valid_out),
        .result    (result)
    );

    //////////////////////////////
    // clock and cycle count
    //////////////////////////////

    initial begin
        clk = 1'b0;
        forever #(clk_period / 2) clk = ~clk;
    end

    always @(posedge clk) begin
        cycle <= cycle + 1;
    end

    // numerical recipes constants
    function automatic logic [31:0] lcg_next(input logic [31:0] s);
        return s * 32'd1664525 + 32'd1013904223;
    endfunction

    //////////////////////////////
    // vector file
    //////////////////////////////

    task automatic load_vectors();
        int          fd;
        int          cnt;
        string       line;
        string       nm;
        logic [31:0] va;
        logic [31:0] vb;
        logic [31:0] ve;
        fd = $fopen(tests_file, "r");
        if (fd == 0) begin
            $display("ERROR: cannot open %s", tests_file);
            errors++;
            return;
        end
        while ($fgets(line, fd) > 0) begin
            // comment lines
            if (line.len() == 0 || line[0] == "#") begin
                continue;
            end
            cnt = $sscanf(line, "%s %h %h %h", nm, va, vb, ve);
            if (cnt == 4) begin
                test_name.push_back(nm);
                op_a.push_back(va);
                op_b.push_back(vb);
                expected.push_back(ve);
            end else if (cnt > 0) begin
                $display("ERROR: malformed line in %s: %s", tests_file, line);
                errors++;
            end
        end
        $fclose(fd);
        n_tests = test_name.size();
    endtask

    //////////////////////////////
    // stimulus
    //////////////////////////////

    task automatic drive_all();
        int i;
        int gap;
        for (i = 0; i < n_tests; i++) begin
            @(negedge clk);
            valid_in = 1'b1;
            a        = op_a[i];
            b        = op_b[i];
            // seen at the negedge after the last pipeline register
            due_cycle.push_back(cycle + fp_add_latency);
            lcg_state = lcg_next(lcg_state);
            // mostly back to back, now and then one or two idle cycles
            if (lcg_state[31:30] == 2'b11) begin
                gap = lcg_state[29] ? 2 : 1;
            end else begin
                gap = 0;
            end
            repeat (gap) begin
                @(negedge clk);
                valid_in = 1'b0;
            end
        end
        @(negedge clk);
        valid_in = 1'b0;
    endtask

    //////////////////////////////
    // response check
    //////////////////////////////

    task automatic check_result();
        int i;
        i = rx_count;
        if (i >= due_cycle.size()) begin
            $display("ERROR: valid_out at cycle %0d with no sum outstanding", cycle);
            errors++;
        end else begin
            if (result !== expected[i]) begin
                $display("CHECK FAILED %s: expected %h, actual %h",
                         test_name[i], expected[i], result);
                errors++;
            end else if (cycle != due_cycle[i]) begin
                $display("CHECK FAILED %s: expected arrival cycle %0d, actual %0d",
                         test_name[i], due_cycle[i], cycle);
                errors++;
            end else begin
                $display("ok   %s  %h + %h = %h", test_name[i], op_a[i], op_b[i], result);
                passed++;
            end
            rx_count++;
        end
    endtask

    // outputs are stable at the falling edge
    initial begin
        forever begin
            @(negedge clk);
            if (valid_out) begin
                check_result();
            end
        end
    end

    //////////////////////////////
    // main sequence
    //////////////////////////////

    initial begin
        rstn     = 1'b0;
        valid_in = 1'b0;
        a        = '0;
        b        = '0;
        load_vectors();
        loaded = 1'b1;
        repeat (5) @(posedge clk);
        @(negedge clk);
        rstn = 1'b1;
        if (n_tests == 0) begin
            $display("ERROR: no test vectors were loaded");
            errors++;
        end else begin
            drive_all();
            wait (rx_count == n_tests);
            // room for any stray strobe to show up
            repeat (fp_add_latency + 2) @(negedge clk);
        end
        errors = errors + dut_i.asserts_i.fail_count;
        $display("tests %0d, passed %0d, errors %0d", n_tests, passed, errors);
        if (errors == 0) begin
            $display("Verification passed");
        end else begin
            $display("Verification failed");
        end
        $finish;
    end

    // watchdog, about three cycles per test plus latency and reset
    initial begin
        wait (loaded);
        #((n_tests * 3 + fp_add_latency + 20) * clk_period);
        $display("ERROR: timeout, %0d of %0d sums never arrived",
                 n_tests - rx_count, n_tests);
        $display("Verification failed");
        $finish;
    end

endmodule

`default_nettype wire

//--- verilog.f
fp_add_pkg.sv
align_shifter.sv
fp_unpack.sv
fp_align.sv
fp_add_norm.sv
fp_round_pack.sv
fp_add_top.sv
fp_add_asserts.sv
tb_fp_add.sv
